// File: verilog/fxp_pkg.sv
package fxp_pkg;

    // Signed Q13 element width
    localparam int DATA_W = 26;

    typedef logic signed [DATA_W-1:0] elem_t;

    // Index 0 is element 1 of the vector
    typedef elem_t [3:0] vec4_t;

    // Four rows, row index first
    typedef vec4_t [3:0] mat4_t;

    // One product matrix per weight row k
    typedef mat4_t [3:0] prod_set_t;

    // Full-width product, arithmetic shift, then truncate to DATA_W
    function automatic elem_t fxp_mul(
        input elem_t a,
        input elem_t b,
        input int    frac
    );
        logic signed [2*DATA_W-1:0] p;
        p = a * b;
        p = p >>> frac;
        return p[DATA_W-1:0];
    endfunction

endpackage

// File: verilog/engine_pkg.sv
package engine_pkg;

    typedef enum logic {
        OP_MUL  = 1'b0,
        OP_PASS = 1'b1
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_COMPUTE = 2'd1,
        ST_DRAIN   = 2'd2
    } ctrl_state_e;

    // Weight row write
    typedef struct packed {
        logic [1:0]     row;
        fxp_pkg::vec4_t data;
    } wr_req_t;

    // Job request
    typedef struct packed {
        opcode_e        op;
        fxp_pkg::vec4_t z;
    } job_req_t;

    // One row of one product matrix
    typedef struct packed {
        logic [1:0]     mat;
        logic [1:0]     row;
        fxp_pkg::vec4_t data;
        logic           last;
    } res_beat_t;

endpackage

// File: verilog/weight_bank.sv
module weight_bank (
    input  logic                clk_mul,
    input  logic                rst,
    input  logic                we,
    input  engine_pkg::wr_req_t wr,
    output fxp_pkg::mat4_t      weights
);

    fxp_pkg::mat4_t w_q;

    // One row per write, addressed by wr.row
    always_ff @(posedge clk_mul) begin
        if (rst) begin
            w_q <= '0;
        end else if (we) begin
            w_q[wr.row] <= wr.data;
        end
    end

    // All rows go out in parallel
    assign weights = w_q;

endmodule

// File: verilog/outer_mul.sv
module outer_mul #(
    parameter int FRAC_BITS = 13
) (
    input  logic                clk_mul,
    input  logic                cap,
    input  logic                en_mul,
    input  fxp_pkg::vec4_t      z,
    input  fxp_pkg::mat4_t      w,
    output fxp_pkg::prod_set_t  prod
);

    fxp_pkg::prod_set_t prod_d;
    fxp_pkg::prod_set_t prod_q;

    // Matrix k is z times weight row k; element (i,j) = z_i * w[k][j]
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    if (en_mul) begin
                        prod_d[k][i][j] = fxp_pkg::fxp_mul(z[i], w[k][j], FRAC_BITS);
                    end else begin
                        // Disabled: each matrix is W itself
                        prod_d[k][i][j] = w[i][j];
                    end
                end
            end
        end
    end

    // Holds between captures
    always_ff @(posedge clk_mul) begin
        if (cap) begin
            prod_q <= prod_d;
        end
    end

    assign prod = prod_q;

endmodule

// File: verilog/result_serializer.sv
module result_serializer (
    input  logic                  clk_mul,
    input  logic                  rst,
    input  logic                  load,
    input  fxp_pkg::prod_set_t    prod,
    output logic                  res_valid,
    input  logic                  res_ready,
    output engine_pkg::res_beat_t res,
    output logic                  done
);

    fxp_pkg::prod_set_t set_q;
    logic [3:0]         beat_cnt;
    logic               valid_q;
    logic               fire;
    logic               last_beat;

    assign last_beat = (beat_cnt == 4'd15);
    assign fire      = valid_q && res_ready;

    // Snapshot of the product set for this job
    always_ff @(posedge clk_mul) begin
        if (load) begin
            set_q <= prod;
        end
    end

    // Beat counter, upper bits select the matrix, lower bits the row
    always_ff @(posedge clk_mul) begin
        if (rst) begin
            beat_cnt <= 4'd0;
            valid_q  <= 1'b0;
        end else if (load) begin
            beat_cnt <= 4'd0;
            valid_q  <= 1'b1;
        end else if (fire) begin
            if (last_beat) begin
                valid_q <= 1'b0;
            end else begin
                beat_cnt <= beat_cnt + 4'd1;
            end
        end
    end

    // Beat stays put while stalled
    always_comb begin
        res.mat  = beat_cnt[3:2];
        res.row  = beat_cnt[1:0];
        res.data = set_q[beat_cnt[3:2]][beat_cnt[1:0]];
        res.last = last_beat;
    end

    assign res_valid = valid_q;

    // Pulse on the final handshake
    assign done = fire && last_beat;

endmodule

// File: verilog/mul_ctrl.sv
module mul_ctrl (
    input  logic                 clk_mul,
    input  logic                 rst,
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  logic                 job_valid,
    output logic                 job_ready,
    input  engine_pkg::job_req_t job,
    output logic                 we,
    output logic                 cap,
    output logic                 en_mul,
    output fxp_pkg::vec4_t       z_hold,
    output logic                 load,
    input  logic                 done
);

    engine_pkg::ctrl_state_e state;
    engine_pkg::opcode_e     op_hold;
    fxp_pkg::vec4_t          z_q;
    logic                    idle;
    logic                    job_fire;
    logic                    load_q;

    assign idle     = (state == engine_pkg::ST_IDLE);
    assign job_fire = job_valid && idle;

    // Weights and jobs only taken when idle
    assign wr_ready  = idle;
    assign job_ready = idle;
    assign we        = wr_valid && idle;

    always_ff @(posedge clk_mul) begin
        if (rst) begin
            state   <= engine_pkg::ST_IDLE;
            op_hold <= engine_pkg::OP_PASS;
            load_q  <= 1'b0;
        end else begin
            // Serializer loads one cycle after capture
            load_q <= cap;
            case (state)
                engine_pkg::ST_IDLE: begin
                    if (job_fire) begin
                        op_hold <= job.op;
                        state   <= engine_pkg::ST_COMPUTE;
                    end
                end
                engine_pkg::ST_COMPUTE: begin
                    state <= engine_pkg::ST_DRAIN;
                end
                engine_pkg::ST_DRAIN: begin
                    // Wait for the last beat to leave
                    if (done) begin
                        state <= engine_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= engine_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Job vector
    always_ff @(posedge clk_mul) begin
        if (job_fire) begin
            z_q <= job.z;
        end
    end

    assign cap    = (state == engine_pkg::ST_COMPUTE);
    assign en_mul = (op_hold == engine_pkg::OP_MUL);
    assign z_hold = z_q;
    assign load   = load_q;

endmodule

// File: verilog/outer_product_engine.sv
module outer_product_engine #(
    parameter int FRAC_BITS = 13
) (
    input  logic                  clk_mul,
    input  logic                  rst,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  engine_pkg::wr_req_t   wr,
    input  logic                  job_valid,
    output logic                  job_ready,
    input  engine_pkg::job_req_t  job,
    output logic                  res_valid,
    input  logic                  res_ready,
    output engine_pkg::res_beat_t res
);

    logic               we;
    logic               cap;
    logic               en_mul;
    logic               load;
    logic               done;
    fxp_pkg::vec4_t     z_hold;
    fxp_pkg::mat4_t     weights;
    fxp_pkg::prod_set_t prod;

    mul_ctrl u_mul_ctrl (
        .clk_mul   (clk_mul),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job       (job),
        .we        (we),
        .cap       (cap),
        .en_mul    (en_mul),
        .z_hold    (z_hold),
        .load      (load),
        .done      (done)
    );

    weight_bank u_weight_bank (
        .clk_mul (clk_mul),
        .rst     (rst),
        .we      (we),
        .wr      (wr),
        .weights (weights)
    );

    outer_mul #(
        .FRAC_BITS (FRAC_BITS)
    ) u_outer_mul (
        .clk_mul (clk_mul),
        .cap     (cap),
        .en_mul  (en_mul),
        .z       (z_hold),
        .w       (weights),
        .prod    (prod)
    );

    result_serializer u_result_serializer (
        .clk_mul   (clk_mul),
        .rst       (rst),
        .load      (load),
        .prod      (prod),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res),
        .done      (done)
    );

endmodule

// File: bench/tb_outer_product_engine.sv
module tb_outer_product_engine;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAC = 13;
    // About 40 jobs at up to 40 cycles each plus margin
    localparam int CYCLE_LIMIT = 4000;

    logic                  clk_mul = 1'b0;
    logic                  rst;
    logic                  wr_valid;
    logic                  wr_ready;
    engine_pkg::wr_req_t   wr;
    logic                  job_valid;
    logic                  job_ready;
    engine_pkg::job_req_t  job;
    logic                  res_valid;
    logic                  res_ready;
    engine_pkg::res_beat_t res;

    logic [31:0]           lfsr_state = 32'h5241;
    string                 test_name = "reset";

    // Reference model state owned by the monitor
    fxp_pkg::mat4_t        w_model = '0;
    engine_pkg::res_beat_t exp_q[$];
    engine_pkg::res_beat_t exp_beat;
    engine_pkg::res_beat_t held_beat;
    bit                    stalled = 1'b0;
    bit                    in_job = 1'b0;
    int                    beat_idx = 0;
    int                    beats_total = 0;
    int                    jobs_accepted = 0;
    int                    wr_blocked = 0;
    int                    value_errors = 0;
    int                    protocol_errors = 0;

    // Owned by the stimulus process
    int                    other_errors = 0;

    int                    cycle_cnt = 0;

    outer_product_engine #(
        .FRAC_BITS (FRAC)
    ) u_outer_product_engine (
        .clk_mul   (clk_mul),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr        (wr),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job       (job),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    always #20 clk_mul = ~clk_mul;

    // Galois LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic fxp_pkg::elem_t rand_elem();
        logic [31:0] raw;
        logic [31:0] mode;
        raw  = take_bits(fxp_pkg::DATA_W);
        mode = take_bits(2);
        if (mode == 0) begin
            return raw[fxp_pkg::DATA_W-1:0];
        end
        // Small magnitude sign extended from 16 bits
        return {{10{raw[15]}}, raw[15:0]};
    endfunction

    function automatic fxp_pkg::vec4_t rand_vec();
        fxp_pkg::vec4_t v;
        for (int e = 0; e < 4; e++) begin
            v[e] = rand_elem();
        end
        return v;
    endfunction

    // Q13 product as a full 64-bit product shifted arithmetically and cut to DATA_W
    function automatic fxp_pkg::elem_t q13_product(
        input fxp_pkg::elem_t a,
        input fxp_pkg::elem_t b
    );
        longint full;
        full = longint'(a) * longint'(b);
        full = full >>> FRAC;
        return full[fxp_pkg::DATA_W-1:0];
    endfunction

    function automatic engine_pkg::res_beat_t expected_beat(
        input engine_pkg::opcode_e op,
        input fxp_pkg::vec4_t      z,
        input fxp_pkg::mat4_t      w,
        input int                  k,
        input int                  i
    );
        engine_pkg::res_beat_t b;
        b.mat  = 2'(k);
        b.row  = 2'(i);
        b.last = (k == 3) && (i == 3);
        for (int j = 0; j < 4; j++) begin
            if (op == engine_pkg::OP_MUL) begin
                b.data[j] = q13_product(z[i], w[k][j]);
            end else begin
                b.data[j] = w[i][j];
            end
        end
        return b;
    endfunction

    task automatic write_row(input logic [1:0] row, input fxp_pkg::vec4_t data);
        @(negedge clk_mul);
        wr_valid = 1'b1;
        wr.row   = row;
        wr.data  = data;
        while (!wr_ready) begin
            @(negedge clk_mul);
        end
        @(negedge clk_mul);
        wr_valid = 1'b0;
    endtask

    // One job that may stall res_ready and hold a write pending during it
    task automatic run_job(
        input engine_pkg::opcode_e op,
        input fxp_pkg::vec4_t      z,
        input bit                  stall,
        input bit                  late_wr,
        input logic [1:0]          wr_row,
        input fxp_pkg::vec4_t      wr_data
    );
        logic [31:0] coin;
        @(negedge clk_mul);
        job_valid = 1'b1;
        job.op    = op;
        job.z     = z;
        while (!job_ready) begin
            @(negedge clk_mul);
        end
        @(negedge clk_mul);
        job_valid = 1'b0;
        if (late_wr) begin
            wr_valid = 1'b1;
            wr.row   = wr_row;
            wr.data  = wr_data;
        end
        while (in_job) begin
            if (stall) begin
                coin      = take_bits(1);
                res_ready = coin[0];
            end else begin
                res_ready = 1'b1;
            end
            @(negedge clk_mul);
        end
        if (late_wr) begin
            while (!wr_ready) begin
                @(negedge clk_mul);
            end
            @(negedge clk_mul);
            wr_valid = 1'b0;
        end
    endtask

    always @(posedge clk_mul) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Monitor and reference model
    always @(posedge clk_mul) begin
        if (!rst) begin
            if (in_job && job_ready) begin
                protocol_errors++;
                $display("ERROR [%s]: job_ready high while a job is in flight", test_name);
            end
            if (!in_job && !job_ready) begin
                protocol_errors++;
                $display("ERROR [%s]: job_ready low with no job in flight", test_name);
            end
            if (wr_ready != job_ready) begin
                protocol_errors++;
                $display("ERROR [%s]: wr_ready and job_ready disagree", test_name);
            end
            if (wr_valid && !wr_ready) begin
                wr_blocked++;
            end
            if (wr_valid && wr_ready) begin
                if (in_job) begin
                    protocol_errors++;
                    $display("ERROR [%s]: weight write accepted during a job", test_name);
                end
                w_model[wr.row] = wr.data;
            end
            if (stalled && (!res_valid || res !== held_beat)) begin
                protocol_errors++;
                $display("ERROR [%s]: result beat changed while stalled", test_name);
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("ERROR [%s]: result beat with no job pending", test_name);
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (res !== exp_beat) begin
                        value_errors++;
                        $display("FAIL %s beat %0d: expected %h, actual %h",
                                 test_name, beat_idx, exp_beat, res);
                    end
                end
                beat_idx++;
                beats_total++;
                if (res.last) begin
                    if (beat_idx != 16) begin
                        protocol_errors++;
                        $display("ERROR [%s]: job ended after %0d beats instead of 16",
                                 test_name, beat_idx);
                    end
                    in_job   = 1'b0;
                    beat_idx = 0;
                end
            end
            stalled   = res_valid && !res_ready;
            held_beat = res;
            // Placed after the write above so a write on the same edge is seen
            if (job_valid && job_ready) begin
                jobs_accepted++;
                in_job = 1'b1;
                for (int k = 0; k < 4; k++) begin
                    for (int i = 0; i < 4; i++) begin
                        exp_q.push_back(expected_beat(job.op, job.z, w_model, k, i));
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] pick;
        rst       = 1'b1;
        wr_valid  = 1'b0;
        wr        = '0;
        job_valid = 1'b0;
        job       = '0;
        res_ready = 1'b0;
        repeat (16) @(negedge clk_mul);
        rst = 1'b0;

        if (res_valid !== 1'b0) begin
            other_errors++;
            $display("FAIL %s res_valid: expected 0, actual %b", test_name, res_valid);
        end
        if (wr_ready !== 1'b1) begin
            other_errors++;
            $display("FAIL %s wr_ready: expected 1, actual %b", test_name, wr_ready);
        end
        if (job_ready !== 1'b1) begin
            other_errors++;
            $display("FAIL %s job_ready: expected 1, actual %b", test_name, job_ready);
        end

        test_name = "pass_readback";
        for (int r = 0; r < 4; r++) begin
            write_row(2'(r), rand_vec());
        end
        run_job(engine_pkg::OP_PASS, rand_vec(), 1'b0, 1'b0, 2'd0, '0);

        test_name = "mul_random";
        for (int n = 0; n < 16; n++) begin
            if (n % 4 == 3) begin
                pick = take_bits(2);
                write_row(pick[1:0], rand_vec());
            end
            run_job(engine_pkg::OP_MUL, rand_vec(), 1'b0, 1'b0, 2'd0, '0);
        end

        test_name = "backpressure";
        for (int n = 0; n < 16; n++) begin
            pick = take_bits(5);
            if (pick[4:3] == 2'd0) begin
                write_row(pick[1:0], rand_vec());
            end
            if (pick[2:0] == 3'd0) begin
                run_job(engine_pkg::OP_PASS, rand_vec(), 1'b1, 1'b0, 2'd0, '0);
            end else begin
                run_job(engine_pkg::OP_MUL, rand_vec(), 1'b1, 1'b0, 2'd0, '0);
            end
        end

        test_name = "write_block";
        for (int n = 0; n < 6; n++) begin
            pick = take_bits(3);
            run_job(engine_pkg::OP_MUL, rand_vec(), pick[2], 1'b1, pick[1:0], rand_vec());
        end
        run_job(engine_pkg::OP_PASS, rand_vec(), 1'b0, 1'b0, 2'd0, '0);

        test_name = "wrap_up";
        repeat (4) @(negedge clk_mul);
        if (exp_q.size() != 0 || in_job) begin
            other_errors++;
            $display("ERROR: %0d expected beats never arrived", exp_q.size());
        end
        if (beats_total != 16 * jobs_accepted) begin
            other_errors++;
            $display("ERROR: %0d beats seen for %0d jobs", beats_total, jobs_accepted);
        end
        if (wr_blocked == 0) begin
            other_errors++;
            $display("ERROR: no weight write was ever held off by wr_ready");
        end

        $display("Errors: value %0d, protocol %0d, other %0d (jobs %0d, beats %0d)",
                 value_errors, protocol_errors, other_errors, jobs_accepted, beats_total);
        if (value_errors + protocol_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/fxp_pkg.sv
verilog/engine_pkg.sv
verilog/weight_bank.sv
verilog/outer_mul.sv
verilog/result_serializer.sv
verilog/mul_ctrl.sv
verilog/outer_product_engine.sv
bench/tb_outer_product_engine.sv

// File: run.sh
#!/bin/sh
# Builds the outer-product engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_outer_product_engine \
    -Mdir obj_dir \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_outer_product_engine)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
